//--- rsc_consts.svh
//------------------------------------------------
// widths, buffer depth and APB map of the RSC encoder
// N is held on RSC_NW bits but the buffer stops at RSC_BUF_DEPTH pairs
//------------------------------------------------
`ifndef RSC_CONSTS_SVH
`define RSC_CONSTS_SVH

// block length
`define RSC_NW         13         // width of N, in pairs
`define RSC_BUF_DEPTH  1024       // max pairs per block
`define RSC_AW         10         // buffer address width
`define RSC_LEN_MIN    13'd3      // shortest legal block

// APB side
`define RSC_APB_AW     8
`define RSC_APB_DW     32
`define RSC_STAT_W     16         // finished block counter
`define RSC_REG_CODE   8'h00      // rw, code rate
`define RSC_REG_LEN    8'h04      // rw, N
`define RSC_REG_STAT   8'h08      // ro, write clears

`endif

//--- rsc_pkg.sv
//------------------------------------------------
// shared types of the duobinary RSC encoder
// circulation lookup is only valid for N mod 7 != 0
//------------------------------------------------
package rsc_pkg;

  // code rate select, only 1/3, 2/5 and 3/7 carry W
  typedef enum logic [3:0] {
    code_1_3 = 4'd0,  code_1_2 = 4'd1,  code_2_3 = 4'd2,  code_3_4 = 4'd3,
    code_4_5 = 4'd4,  code_5_6 = 4'd5,  code_6_7 = 4'd6,  code_7_8 = 4'd7,
    code_8_9 = 4'd8,  code_9_10 = 4'd9, code_2_5 = 4'd10, code_3_5 = 4'd11,
    code_3_7 = 4'd12
  } rsc_code_t;

  typedef enum logic [1:0] {
    stage_pre = 2'd0,   // zero start, no output
    stage_y   = 2'd1,   // A, B and Y
    stage_w   = 2'd2    // W only
  } rsc_stage_t;

  typedef enum logic [2:0] {
    st_reset, st_wait, st_init_sc, st_data,
    st_load_sc, st_py, st_init_addr, st_pw
  } rsc_ctrl_state_t;

  // circulation state from N mod 7 and the pre-pass end state
  // candidate x is correct when zero-input advance of x, xor end state, gives x
  function automatic logic [2:0] rsc_circ_state(input logic [2:0] n_mod7,
                                                input logic [2:0] s_end);
    logic [2:0] adv;
    logic [2:0] sc;
    sc = '0;
    for (int x = 0; x < 8; x++) begin
      adv = x[2:0];
      for (int k = 0; k < 6; k++) begin
        if (k < n_mod7) adv = {adv[1] ^ adv[0], adv[2], adv[1]}; // {s1,s2,s3}
      end
      if ((adv ^ s_end) == x[2:0]) sc = x[2:0];
    end
    return sc;
  endfunction

endpackage

//--- rsc_apb_regs.sv
//------------------------------------------------
// APB config block, no wait states, pslverr on unmapped offsets
// LEN is clamped to RSC_LEN_MIN .. RSC_BUF_DEPTH on write
//------------------------------------------------
`timescale 1ns/10ps
`include "rsc_consts.svh"

module rsc_apb_regs (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic [`RSC_APB_AW-1:0] paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`RSC_APB_DW-1:0] pwdata,
  input  logic                   blk_done,
  output logic [`RSC_APB_DW-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  output rsc_pkg::rsc_code_t     code,
  output logic [`RSC_NW-1:0]     n_len
);
  import rsc_pkg::*;

  logic                   acc;        // access phase
  logic                   wr_en;
  logic                   hit_code;
  logic                   hit_len;
  logic                   hit_stat;
  logic [`RSC_NW-1:0]     len_wr;     // clamped write value
  logic [`RSC_STAT_W-1:0] stat_cnt;

  //------------------------------------------------
  // decode
  //------------------------------------------------
  assign acc      = psel & penable;
  assign wr_en    = acc & pwrite;
  assign hit_code = (paddr == `RSC_REG_CODE);
  assign hit_len  = (paddr == `RSC_REG_LEN);
  assign hit_stat = (paddr == `RSC_REG_STAT);

  assign pready   = 1'b1;                                 // never stalls
  assign pslverr  = acc & ~(hit_code | hit_len | hit_stat);

  always_comb begin
    len_wr = pwdata[`RSC_NW-1:0];
    if (len_wr < `RSC_LEN_MIN) len_wr = `RSC_LEN_MIN;
    else if (len_wr > `RSC_NW'(`RSC_BUF_DEPTH)) len_wr = `RSC_NW'(`RSC_BUF_DEPTH);
  end

  //------------------------------------------------
  // registers
  //------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      code     <= code_1_3;
      n_len    <= `RSC_LEN_MIN;
      stat_cnt <= '0;
    end else begin
      if (wr_en & hit_code) code  <= rsc_code_t'(pwdata[3:0]);
      if (wr_en & hit_len)  n_len <= len_wr;
      if (wr_en & hit_stat) stat_cnt <= '0;             // any write clears
      else if (blk_done)    stat_cnt <= stat_cnt + 1'b1;
    end
  end

  // read mux, zero extended
  always_comb begin
    prdata = '0;
    if (hit_code)      prdata = `RSC_APB_DW'(code);
    else if (hit_len)  prdata = `RSC_APB_DW'(n_len);
    else if (hit_stat) prdata = `RSC_APB_DW'(stat_cnt);
  end

endmodule

//--- rsc_in_buf.sv
//------------------------------------------------
// dibit input buffer, one block at a time
// writes while full are dropped, full clears only on buf_release
// n_len must not change while a block is being written
//------------------------------------------------
`timescale 1ns/10ps
`include "rsc_consts.svh"

module rsc_in_buf (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               in_wr,
  input  logic               in_a,
  input  logic               in_b,
  input  logic [`RSC_NW-1:0] n_len,
  input  logic               buf_release,
  input  logic               addr_clear,
  input  logic               addr_enable,
  output logic               full,
  output logic               rd_a,
  output logic               rd_b
);

  logic [1:0]         mem [`RSC_BUF_DEPTH];   // {a, b} per pair
  logic [`RSC_NW-1:0] wr_cnt;
  logic [`RSC_NW-1:0] wr_cnt_nxt;
  logic               wr_ok;
  logic [`RSC_AW-1:0] rd_addr;

  //------------------------------------------------
  // write side
  //------------------------------------------------
  assign wr_ok      = in_wr & ~full;
  assign wr_cnt_nxt = wr_cnt + 1'b1;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_cnt <= '0;
      full   <= 1'b0;
    end else if (buf_release) begin        // block consumed
      wr_cnt <= '0;
      full   <= 1'b0;
    end else if (wr_ok) begin
      wr_cnt <= wr_cnt_nxt;
      full   <= (wr_cnt_nxt == n_len);     // Nth pair closes the block
    end
  end

  always_ff @(posedge iclk) begin
    if (wr_ok) begin
      mem[wr_cnt[`RSC_AW-1:0]] <= {in_a, in_b};
    end
  end

  //------------------------------------------------
  // read side, replaces the separate address generator
  //------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_addr <= '0;
    end else if (addr_clear) begin
      rd_addr <= '0;                       // start of every pass
    end else if (addr_enable) begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  // data valid one clock after addr_enable
  always_ff @(posedge iclk) begin
    if (addr_enable) begin
      {rd_a, rd_b} <= mem[rd_addr];
    end
  end

endmodule

//--- rsc_enc_ctrl.sv
//------------------------------------------------
// pass sequencer, pre pass then Y then optional W
// every step costs one sym_ena strobe, N >= 3 assumed
// code and N are sampled at init_sc, so changes apply next block
//------------------------------------------------
`timescale 1ns/10ps
`include "rsc_consts.svh"

module rsc_enc_ctrl (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                sym_ena,
  input  rsc_pkg::rsc_code_t  code,
  input  logic [`RSC_NW-1:0]  n_len,
  input  logic                buf_full,
  input  logic                oblock_ready,
  output logic                buf_release,
  output logic                addr_clear,
  output logic                addr_enable,
  output logic                state_clear,
  output logic                state_load,
  output logic                sym_val,
  output logic                sym_sop,
  output logic                sym_eop,
  output rsc_pkg::rsc_stage_t stage
);
  import rsc_pkg::*;

  rsc_ctrl_state_t    state;
  rsc_ctrl_state_t    last_pass;      // pass that closes the block
  logic               nopw;           // code without W parity
  logic [`RSC_NW-1:0] num_m2;         // N - 2, counter runs one behind
  logic [`RSC_NW-1:0] cnt;
  logic               cnt_zero;       // first pair of the pass
  logic               cnt_done;       // last pair of the pass
  logic               blk_start;

  //------------------------------------------------
  // FSM
  //------------------------------------------------
  assign blk_start = buf_full & oblock_ready;
  assign last_pass = nopw ? st_py : st_pw;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= st_reset;
    end else if (sym_ena) begin
      case (state)
        st_reset     : state <= blk_start ? st_wait : st_reset;
        st_wait      : state <= st_init_sc;
        st_init_sc   : state <= st_data;
        st_data      : state <= cnt_done ? st_load_sc : st_data;
        st_load_sc   : state <= st_py;
        st_py        : state <= cnt_done ? (nopw ? st_reset : st_init_addr) : st_py;
        st_init_addr : state <= st_pw;
        st_pw        : state <= cnt_done ? st_reset : st_pw;
        default      : state <= st_reset;
      endcase
    end
  end

  //------------------------------------------------
  // pass counter and block parameters
  //------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      nopw     <= 1'b0;
      num_m2   <= '0;
      cnt      <= '0;
      cnt_zero <= 1'b0;
      cnt_done <= 1'b0;
    end else if (sym_ena) begin
      if (state == st_init_sc) begin
        nopw   <= (code != code_1_3) && (code != code_2_5) && (code != code_3_7);
        num_m2 <= n_len - 2'd2;
      end
      if (addr_clear) begin
        cnt      <= '0;
        cnt_zero <= 1'b1;
        cnt_done <= 1'b0;
      end else begin
        cnt      <= cnt + 1'b1;
        cnt_zero <= 1'b0;
        cnt_done <= (cnt == num_m2);      // flags pair N-1
      end
    end
  end

  //------------------------------------------------
  // strobes, all on sym_ena
  //------------------------------------------------
  assign addr_clear  = sym_ena & ((state == st_init_sc) | (state == st_load_sc) |
                                  (state == st_init_addr));
  assign addr_enable = sym_ena & ((state == st_data) | (state == st_py) | (state == st_pw));

  assign state_clear = sym_ena & (state == st_init_sc);
  assign state_load  = sym_ena & (state == st_load_sc);

  assign sym_val     = addr_enable;             // every pair, engine drops pre pass
  assign sym_sop     = addr_enable & cnt_zero;
  assign sym_eop     = addr_enable & cnt_done;
  assign buf_release = sym_eop & (state == last_pass);

  // held for the whole pass
  always_comb begin
    case (state)
      st_py   : stage = stage_y;
      st_pw   : stage = stage_w;
      default : stage = stage_pre;
    endcase
  end

endmodule

//--- rsc_enc_engine.sv
//------------------------------------------------
// duobinary RSC core, state {s1,s2,s3}
// outputs come 2 iclk after the controller strobe
// W pass relies on the Y pass ending back on the circulation state
//------------------------------------------------
`timescale 1ns/10ps

module rsc_enc_engine (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                state_clear,
  input  logic                state_load,
  input  logic                sym_val,
  input  logic                sym_sop,
  input  logic                sym_eop,
  input  rsc_pkg::rsc_stage_t stage,
  input  logic                rd_a,
  input  logic                rd_b,
  output logic                out_val,
  output logic                out_sop,
  output logic                out_eop,
  output rsc_pkg::rsc_stage_t out_stage,
  output logic                out_a,
  output logic                out_b,
  output logic                out_p
);
  import rsc_pkg::*;

  logic       clear_d;
  logic       load_d;
  logic       val_d;
  logic       sop_d;
  logic       eop_d;
  rsc_stage_t stage_d;
  logic [2:0] st;         // {s1, s2, s3}
  logic [2:0] st_nxt;
  logic [2:0] n_mod7;     // pre pass length mod 7
  logic       t;
  logic       par_y;
  logic       par_w;
  logic       emit;       // pair goes out

  //------------------------------------------------
  // align strobes with buffer read data
  //------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      clear_d <= 1'b0;
      load_d  <= 1'b0;
      val_d   <= 1'b0;
      sop_d   <= 1'b0;
      eop_d   <= 1'b0;
      stage_d <= stage_pre;
    end else begin
      clear_d <= state_clear;
      load_d  <= state_load;
      val_d   <= sym_val;
      sop_d   <= sym_sop;
      eop_d   <= sym_eop;
      stage_d <= stage;
    end
  end

  //------------------------------------------------
  // trellis step
  //------------------------------------------------
  assign t      = rd_a ^ rd_b ^ st[1] ^ st[0];
  assign st_nxt = {t, st[2] ^ rd_b, st[1] ^ rd_b};
  assign par_y  = t ^ st[2] ^ st[0];
  assign par_w  = t ^ st[0];
  assign emit   = val_d & (stage_d != stage_pre);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      st     <= '0;
      n_mod7 <= '0;
    end else if (clear_d) begin
      st     <= '0;                               // pre pass from zero
      n_mod7 <= '0;
    end else if (load_d) begin
      st     <= rsc_circ_state(n_mod7, st);       // st holds the pre pass end
    end else if (val_d) begin
      st     <= st_nxt;
      if (stage_d == stage_pre) begin
        n_mod7 <= (n_mod7 == 3'd6) ? 3'd0 : n_mod7 + 1'b1;
      end
    end
  end

  //------------------------------------------------
  // output registers
  //------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_val   <= 1'b0;
      out_sop   <= 1'b0;
      out_eop   <= 1'b0;
      out_stage <= stage_pre;
    end else begin
      out_val   <= emit;
      out_sop   <= emit & sop_d;
      out_eop   <= emit & eop_d;
      out_stage <= stage_d;
    end
  end

  // payload, systematic bits only in Y pass
  always_ff @(posedge iclk) begin
    out_a <= (stage_d == stage_y) & rd_a;
    out_b <= (stage_d == stage_y) & rd_b;
    out_p <= (stage_d == stage_w) ? par_w : par_y;
  end

endmodule

//--- rsc_enc_top.sv
//------------------------------------------------
// RSC encoder top, APB config plus dibit stream in
// sink must take one item per sym_ena once oblock_ready starts a block
//------------------------------------------------
`timescale 1ns/10ps
`include "rsc_consts.svh"

module rsc_enc_top (
  input  logic                   iclk,
  input  logic                   ireset,
  // APB
  input  logic [`RSC_APB_AW-1:0] paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`RSC_APB_DW-1:0] pwdata,
  output logic [`RSC_APB_DW-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  // source side
  input  logic                   in_wr,
  input  logic                   in_a,
  input  logic                   in_b,
  output logic                   in_full,
  // pacing
  input  logic                   sym_ena,
  input  logic                   oblock_ready,
  // sink side
  output logic                   out_val,
  output logic                   out_sop,
  output logic                   out_eop,
  output rsc_pkg::rsc_stage_t    out_stage,
  output logic                   out_a,
  output logic                   out_b,
  output logic                   out_p
);
  import rsc_pkg::*;

  rsc_code_t          code;
  logic [`RSC_NW-1:0] n_len;
  logic               buf_release;   // also bumps STAT
  logic               addr_clear;
  logic               addr_enable;
  logic               state_clear;
  logic               state_load;
  logic               sym_val;
  logic               sym_sop;
  logic               sym_eop;
  rsc_stage_t         stage;
  logic               rd_a;
  logic               rd_b;

  rsc_apb_regs u_apb_regs (
    .iclk, .ireset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .blk_done (buf_release),
    .prdata, .pready, .pslverr, .code, .n_len
  );

  rsc_in_buf u_in_buf (
    .iclk, .ireset, .in_wr, .in_a, .in_b, .n_len,
    .buf_release, .addr_clear, .addr_enable,
    .full (in_full),
    .rd_a, .rd_b
  );

  rsc_enc_ctrl u_enc_ctrl (
    .iclk, .ireset, .sym_ena, .code, .n_len,
    .buf_full (in_full),
    .oblock_ready, .buf_release, .addr_clear, .addr_enable,
    .state_clear, .state_load, .sym_val, .sym_sop, .sym_eop, .stage
  );

  rsc_enc_engine u_enc_engine (
    .iclk, .ireset, .state_clear, .state_load, .sym_val, .sym_sop, .sym_eop,
    .stage, .rd_a, .rd_b,
    .out_val, .out_sop, .out_eop, .out_stage, .out_a, .out_b, .out_p
  );

endmodule

//--- rsc_enc_tb.sv
//------------------------------------------------
// self-checking testbench for the RSC encoder top
// block lengths with N mod 7 = 0 are never generated
//------------------------------------------------
`timescale 1ns/10ps
`include "rsc_consts.svh"

module rsc_enc_tb;
  import rsc_pkg::*;

  logic                   iclk;
  logic                   ireset;
  logic [`RSC_APB_AW-1:0] paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`RSC_APB_DW-1:0] pwdata;
  logic [`RSC_APB_DW-1:0] prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   in_wr;
  logic                   in_a;
  logic                   in_b;
  logic                   in_full;
  logic                   sym_ena;
  logic                   oblock_ready;
  logic                   out_val;
  logic                   out_sop;
  logic                   out_eop;
  rsc_stage_t             out_stage;
  logic                   out_a;
  logic                   out_b;
  logic                   out_p;

  logic        blk_a [`RSC_BUF_DEPTH];   // source block, kept for the model
  logic        blk_b [`RSC_BUF_DEPTH];
  logic [6:0]  exp_q [$];                // {stage, sop, eop, a, b, p}
  logic [31:0] ena_lfsr;                 // sym_ena bits
  logic [31:0] dat_lfsr;                 // data, N and hold bits
  logic        hold_check;               // oblock_ready is low

  rsc_enc_top u_rsc_enc_top (.*);

  initial begin
    iclk = 1'b0;
    forever #2 iclk = ~iclk;             // 4 ns period
  end

  // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  always @(posedge iclk) begin
    ena_lfsr = lfsr_next(ena_lfsr);
    sym_ena <= ena_lfsr[0];
  end

  //------------------------------------------------
  // reference model
  //------------------------------------------------
  // one trellis step, returns {s1', s2', s3', parity}
  function automatic logic [3:0] ref_step(input logic [2:0] s, input logic a,
                                          input logic b, input logic w_pass);
    logic s1;
    logic s2;
    logic s3;
    logic t;
    {s1, s2, s3} = s;
    t = a ^ b ^ s2 ^ s3;
    return {t, s1 ^ b, s2 ^ b, w_pass ? (t ^ s3) : (t ^ s1 ^ s3)};
  endfunction

  // brute force: the start state that comes back to itself, {found, state}
  function automatic logic [3:0] find_circ(input int n);
    logic [3:0] r;
    logic [2:0] s;
    logic [3:0] found;
    found = 4'b0;
    for (int x = 0; x < 8; x++) begin
      s = x[2:0];
      for (int k = 0; k < n; k++) begin
        r = ref_step(s, blk_a[k], blk_b[k], 1'b0);
        s = r[3:1];
      end
      if (s == x[2:0]) found = {1'b1, x[2:0]};
    end
    return found;
  endfunction

  //------------------------------------------------
  // reporting and compare tasks
  //------------------------------------------------
  task automatic report_failure(input string msg);
    $display("TEST FAIL");
    $display("%s", msg);
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("error, time %0t, %s, got %0b, expected %0b",
                               $time, name, got, exp));
  endtask

  task automatic check_dibit(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
      report_failure($sformatf("error, time %0t, %s, got %02b, expected %02b",
                               $time, name, got, exp));
  endtask

  task automatic check_stage(input string name, input rsc_stage_t got, input rsc_stage_t exp);
    if (got !== exp)
      report_failure($sformatf("error, time %0t, %s, got %0d, expected %0d",
                               $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      report_failure($sformatf("error, time %0t, %s, got %0h, expected %0h",
                               $time, name, got, exp));
  endtask

  // pops one expected item per out_val
  always @(negedge iclk) begin : compare_out
    logic [6:0] item;
    if (ireset === 1'b0) begin
      if (hold_check && out_val !== 1'b0)
        report_failure("out_val went high while oblock_ready was low");
      if (out_val === 1'b1) begin
        if (exp_q.size() == 0) begin
          report_failure("out_val high with no output item expected");
        end else begin
          item = exp_q.pop_front();
          check_stage("out_stage", out_stage, rsc_stage_t'(item[6:5]));
          check_bit("out_sop", out_sop, item[4]);
          check_bit("out_eop", out_eop, item[3]);
          check_dibit("out_a_b", {out_a, out_b}, item[2:1]);
          check_bit("out_p", out_p, item[0]);
        end
      end
    end
  end

  //------------------------------------------------
  // APB driver
  //------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int unsigned n;
    @(posedge iclk);
    psel    <= 1'b1;                     // setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge iclk);
    penable <= 1'b1;                     // access phase
    n = 0;
    @(negedge iclk);
    while (pready !== 1'b1) begin
      n++;
      if (n > 16) report_failure("APB pready never came");
      @(negedge iclk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge iclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_bit("pslverr", err, 1'b0);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'h0, data, err);
    check_bit("pslverr", err, 1'b0);
  endtask

  //------------------------------------------------
  // stimulus helpers
  //------------------------------------------------
  task automatic draw_bits(input int w, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < w; i++) begin
      dat_lfsr = lfsr_next(dat_lfsr);
      v = {v[30:0], dat_lfsr[0]};
    end
  endtask

  task automatic pick_len(output int n);
    logic [31:0] r;
    draw_bits(6, r);
    n = 3 + int'(r);
    if (n % 7 == 0) n = n + 1;           // no circulation state there
  endtask

  task automatic wait_full(input logic level, input int unsigned tmo);
    int unsigned n;
    n = 0;
    @(negedge iclk);
    while (in_full !== level) begin
      n++;
      if (n > tmo) report_failure($sformatf("in_full never went to %0b", level));
      @(negedge iclk);
    end
  endtask

  task automatic wait_drain(input int unsigned tmo);
    int unsigned n;
    n = 0;
    @(posedge iclk);
    while (exp_q.size() != 0) begin
      n++;
      if (n > tmo) report_failure("expected output items never came out");
      @(posedge iclk);
    end
  endtask

  // expected items of one block: Y pass, then W pass for codes with W
  task automatic push_expected(input int n, input rsc_code_t code);
    logic [3:0] circ;
    logic [3:0] r;
    logic [2:0] s;
    circ = find_circ(n);
    if (!circ[3]) report_failure("model found no circulation state for this block");
    s = circ[2:0];
    for (int i = 0; i < n; i++) begin
      r = ref_step(s, blk_a[i], blk_b[i], 1'b0);
      exp_q.push_back({stage_y, i == 0, i == n - 1, blk_a[i], blk_b[i], r[0]});
      s = r[3:1];
    end
    if ((code == code_1_3) || (code == code_2_5) || (code == code_3_7)) begin
      s = circ[2:0];                     // W pass restarts from circulation
      for (int i = 0; i < n; i++) begin
        r = ref_step(s, blk_a[i], blk_b[i], 1'b1);
        exp_q.push_back({stage_w, i == 0, i == n - 1, 1'b0, 1'b0, r[0]});
        s = r[3:1];
      end
    end
  endtask

  // configure, refill, optionally hold off the sink, then drain and check STAT
  task automatic run_block(input rsc_code_t code, input int n, input logic hold);
    logic [31:0] stat0;
    logic [31:0] rd;
    logic [31:0] r;
    int unsigned tmo;
    tmo = 20 * n + 400;
    apb_read(`RSC_REG_STAT, stat0);
    apb_write(`RSC_REG_CODE, 32'(code));
    apb_write(`RSC_REG_LEN, 32'(n));
    if (hold) begin
      @(posedge iclk);
      oblock_ready <= 1'b0;
      hold_check = 1'b1;
    end
    wait_full(1'b0, tmo);                // refill only after release
    for (int i = 0; i < n; i++) begin
      draw_bits(2, r);
      blk_a[i] = r[1];
      blk_b[i] = r[0];
      @(posedge iclk);
      in_wr <= 1'b1;
      in_a  <= r[1];
      in_b  <= r[0];
    end
    @(posedge iclk);
    in_wr <= 1'b0;
    push_expected(n, code);
    wait_full(1'b1, tmo);
    if (hold) begin
      repeat (6 * n + 64) @(posedge iclk);   // full buffer, sink off for a whole pre pass
      oblock_ready <= 1'b1;
      hold_check = 1'b0;
    end
    wait_drain(tmo);
    wait_full(1'b0, tmo);
    apb_read(`RSC_REG_STAT, rd);
    check_word("STAT", rd, stat0 + 32'd1);
  endtask

  //------------------------------------------------
  // main sequence
  //------------------------------------------------
  initial begin : main
    logic [31:0] rd;
    logic [31:0] r;
    logic        err;
    int          n;
    ireset       = 1'b1;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    in_wr        = 1'b0;
    in_a         = 1'b0;
    in_b         = 1'b0;
    sym_ena      = 1'b0;
    oblock_ready = 1'b0;
    ena_lfsr     = 32'h9f55;
    dat_lfsr     = 32'h9f55;
    hold_check   = 1'b0;
    repeat (4) @(posedge iclk);
    ireset       <= 1'b0;
    oblock_ready <= 1'b1;
    @(negedge iclk);
    check_bit("out_val", out_val, 1'b0);
    check_bit("in_full", in_full, 1'b0);

    // register access
    apb_read(`RSC_REG_STAT, rd);
    check_word("STAT", rd, 32'd0);
    apb_write(`RSC_REG_CODE, 32'd7);
    apb_read(`RSC_REG_CODE, rd);
    check_word("CODE", rd, 32'd7);
    apb_write(`RSC_REG_LEN, 32'd25);
    apb_read(`RSC_REG_LEN, rd);
    check_word("LEN", rd, 32'd25);
    apb_xfer(1'b0, 8'h0c, 32'h0, rd, err);   // unmapped
    check_bit("pslverr", err, 1'b1);

    pick_len(n);
    run_block(code_1_3, n, 1'b0);        // Y and W passes
    pick_len(n);
    run_block(code_5_6, n, 1'b0);        // Y pass only

    // back to back blocks, sink randomly held off
    for (int i = 0; i < 6; i++) begin
      pick_len(n);
      draw_bits(1, r);
      run_block(i[0] ? code_3_7 : code_2_5, n, (i == 0) | r[0]);
    end

    apb_write(`RSC_REG_STAT, 32'h0);     // write clears the count
    apb_read(`RSC_REG_STAT, rd);
    check_word("STAT", rd, 32'd0);
    repeat (40) @(posedge iclk);         // stray items would fail here
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
rsc_pkg.sv
rsc_apb_regs.sv
rsc_in_buf.sv
rsc_enc_ctrl.sv
rsc_enc_engine.sv
rsc_enc_top.sv
rsc_enc_tb.sv
